//--- Makefile
VERILATOR ?= verilator
TOP       := tb_hsk_udp_write
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
CASES     := sim/hsk_write_cases.txt
LOG       := sim.log
PASS_MSG  := STATUS: PASS

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the binary reads the cases file relative to the project root
run: $(SIM_BIN) $(CASES)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
hw/hsk_spi_pkg.sv
hw/hsk_net_pkg.sv
hw/hsk_spi_capture.sv
hw/hsk_byte_packer.sv
hw/hsk_sync_fifo.sv
hw/hsk_udp_write.sv
sim/tb_hsk_udp_write.sv

//--- hw/hsk_byte_packer.sv
`timescale 1ns/1ps
`default_nettype none

module hsk_byte_packer (
    input  wire                       aclk,
    input  wire                       rst_n,
    input  wire hsk_spi_pkg::spi_byte_t byte_data,
    input  wire                       byte_valid,
    input  wire                       byte_last,
    output hsk_net_pkg::stream_word_t word_data,
    output hsk_net_pkg::keep_t        word_keep,
    output logic                      word_last,
    output logic                      word_valid
);
    import hsk_net_pkg::*;

    // word under construction, lane 0 filled first
    stream_word_t acc_data;
    keep_t        acc_keep;
    lane_idx_t    lane;

    // accumulator with the incoming byte merged in
    stream_word_t next_data;
    keep_t        next_keep;
    logic         word_done;

    always_comb begin
        next_data = acc_data;
        next_keep = acc_keep;
        next_data[8*lane +: 8] = byte_data;
        next_keep[lane] = 1'b1;
    end

    // full word or end of frame closes the word
    assign word_done = byte_valid &&
                       (byte_last || (lane == lane_idx_t'(BYTES_PER_WORD - 1)));

    // accumulator cleared after each word, so idle lanes read zero
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_data <= '0;
            acc_keep <= '0;
            lane     <= '0;
        end else if (word_done) begin
            acc_data <= '0;
            acc_keep <= '0;
            lane     <= '0;
        end else if (byte_valid) begin
            acc_data <= next_data;
            acc_keep <= next_keep;
            lane     <= lane + lane_idx_t'(1);
        end
    end

    // word payload, only meaningful with word_valid
    always_ff @(posedge aclk) begin
        if (word_done) begin
            word_data <= next_data;
            word_keep <= next_keep;
            word_last <= byte_last;
        end
    end

    // one cycle after the closing byte strobe
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
        end
    end

endmodule

`default_nettype wire

//--- hw/hsk_net_pkg.sv
`default_nettype none

package hsk_net_pkg;

    // payload stream word and its byte enables
    parameter int BYTES_PER_WORD = 8;
    typedef logic [8*BYTES_PER_WORD-1:0] stream_word_t;
    typedef logic [BYTES_PER_WORD-1:0] keep_t;
    typedef logic [$clog2(BYTES_PER_WORD)-1:0] lane_idx_t;

    // udp header fields
    typedef logic [11:0] udp_len_t;
    typedef logic [15:0] ip_lo_t;
    typedef logic [15:0] udp_port_t;

    // header stream word
    // [63:48] zero, [47:32] address, [31:16] port, [15:12] zero, [11:0] length
    typedef logic [63:0] hdr_word_t;

    // udp header size, the length field counts it too
    parameter udp_len_t UDP_HDR_BYTES = udp_len_t'(8);

    // fifo entry widths
    // payload entry is {last, keep, data}
    parameter int PKT_ENTRY_W = 1 + BYTES_PER_WORD + 8*BYTES_PER_WORD;
    // header entry is {address, port, length}
    parameter int HDR_ENTRY_W = $bits(ip_lo_t) + $bits(udp_port_t) + $bits(udp_len_t);

endpackage

`default_nettype wire

//--- hw/hsk_spi_capture.sv
`timescale 1ns/1ps
`default_nettype none

module hsk_spi_capture (
    input  wire                    aclk,
    input  wire                    rst_n,
    input  wire                    sclk,
    input  wire                    mosi,
    input  wire                    cs_b,
    output hsk_spi_pkg::spi_byte_t byte_data,
    output logic                   byte_valid,
    output logic                   byte_last
);
    import hsk_spi_pkg::*;

    // pin history, oldest sample in the top bit
    spi_sync_t                  sclk_sync;
    spi_sync_t                  cs_sync;
    // mosi needs no edge stage, only the aligned sample
    logic [SPI_SYNC_STAGES-2:0] mosi_sync;

    logic      sclk_rise;
    logic      cs_rise;
    logic      cs_low;
    logic      mosi_bit;

    // marker-bit shift register and the byte holding register
    spi_byte_t shift_reg;
    spi_byte_t hold_data;
    logic      hold_valid;

    logic      byte_done;
    logic      release_next;
    logic      release_last;

    // cs_b idles high, so reset it high to avoid a false rising edge
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
        end else begin
            sclk_sync <= {sclk_sync[SPI_SYNC_STAGES-2:0], sclk};
            cs_sync   <= {cs_sync[SPI_SYNC_STAGES-2:0], cs_b};
        end
    end

    // same depth as the sclk sample that flags the edge
    always_ff @(posedge aclk) begin
        mosi_sync <= {mosi_sync[SPI_SYNC_STAGES-3:0], mosi};
    end

    assign sclk_rise = sclk_sync[SPI_SYNC_STAGES-1:SPI_SYNC_STAGES-2] == 2'b01;
    assign cs_rise   = cs_sync[SPI_SYNC_STAGES-1:SPI_SYNC_STAGES-2] == 2'b01;
    assign cs_low    = !cs_sync[SPI_SYNC_STAGES-2];
    // mosi was sampled together with the first high sclk sample
    assign mosi_bit  = mosi_sync[SPI_SYNC_STAGES-2];

    // eighth bit of a byte: marker sits in the top bit
    assign byte_done    = cs_low && sclk_rise && shift_reg[SPI_BYTE_BITS-1];
    // first bit of the following byte frees the held one as non-last
    assign release_next = cs_low && sclk_rise && (shift_reg == SHIFT_MARKER) && hold_valid;
    // end of frame frees it as last
    assign release_last = cs_rise && hold_valid;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= SHIFT_MARKER;
        end else if (!cs_low) begin
            // partial bits of an unfinished byte are lost here
            shift_reg <= SHIFT_MARKER;
        end else if (sclk_rise) begin
            if (shift_reg[SPI_BYTE_BITS-1]) begin
                shift_reg <= SHIFT_MARKER;
            end else begin
                shift_reg <= {shift_reg[SPI_BYTE_BITS-2:0], mosi_bit};
            end
        end
    end

    // capture and release never fall in the same cycle
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (byte_done) begin
            hold_valid <= 1'b1;
        end else if (release_next || release_last) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (byte_done) begin
            hold_data <= {shift_reg[SPI_BYTE_BITS-2:0], mosi_bit};
        end
        if (release_next || release_last) begin
            byte_data <= hold_data;
        end
    end

    // registered one-cycle strobe toward the packer
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
        end else begin
            byte_valid <= release_next || release_last;
            byte_last  <= release_last;
        end
    end

endmodule

`default_nettype wire

//--- hw/hsk_spi_pkg.sv
`default_nettype none

package hsk_spi_pkg;

    // one byte as it comes off the SPI link, MSB first
    parameter int SPI_BYTE_BITS = 8;
    typedef logic [SPI_BYTE_BITS-1:0] spi_byte_t;

    // flop history of each SPI pin in the aclk domain
    // two stages resolve metastability, the extra one gives the edge
    parameter int SPI_SYNC_STAGES = 3;
    typedef logic [SPI_SYNC_STAGES-1:0] spi_sync_t;

    // start value of the marker shift register
    // the 1 reaches the top bit after seven shifts
    parameter spi_byte_t SHIFT_MARKER = spi_byte_t'(1);

endpackage

`default_nettype wire

//--- hw/hsk_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module hsk_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire              aclk,
    input  wire              rst_n,
    input  wire [WIDTH-1:0]  wr_data,
    input  wire              wr_en,
    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid
);
    // pointer and count widths, count must reach DEPTH itself
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;

    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full  = count == CW'(DEPTH);
    // writes on full and reads on empty are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && rd_valid;

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // explicit wrap allows depths that are not a power of two
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            if (do_wr && !do_rd) begin
                count <= count + CW'(1);
            end else if (do_rd && !do_wr) begin
                count <= count - CW'(1);
            end
        end
    end

    // first-word fall-through, head entry always on the output
    assign rd_data  = mem[rd_ptr];
    assign rd_valid = count != '0;

endmodule

`default_nettype wire

//--- hw/hsk_udp_write.sv
`timescale 1ns/1ps
`default_nettype none

module hsk_udp_write #(
    parameter int PKT_DEPTH = 512,
    parameter int HDR_DEPTH = 16
) (
    input  wire                        aclk,
    input  wire                        rst_n,
    input  wire                        sclk,
    input  wire                        mosi,
    input  wire                        cs_b,
    input  wire hsk_net_pkg::ip_lo_t   ip_i,
    input  wire hsk_net_pkg::udp_port_t port_i,
    // header stream
    output hsk_net_pkg::hdr_word_t     hdr_tdata,
    output logic                       hdr_tvalid,
    input  wire                        hdr_tready,
    // payload stream
    output hsk_net_pkg::stream_word_t  data_tdata,
    output hsk_net_pkg::keep_t         data_tkeep,
    output logic                       data_tlast,
    output logic                       data_tvalid,
    input  wire                        data_tready
);
    import hsk_spi_pkg::*;
    import hsk_net_pkg::*;

    // capture to packer byte strobe
    spi_byte_t    byte_data;
    logic         byte_valid;
    logic         byte_last;

    // packer to payload fifo word strobe
    stream_word_t word_data;
    keep_t        word_keep;
    logic         word_last;
    logic         word_valid;

    // udp length of the frame in progress, header included
    udp_len_t     len_cnt;
    logic         hdr_wr;

    logic [PKT_ENTRY_W-1:0] pkt_dout;
    logic                   pkt_rd;
    logic [HDR_ENTRY_W-1:0] hdr_dout;
    logic                   hdr_rd;

    hsk_spi_capture u_capture (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_b       (cs_b),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_last  (byte_last)
    );

    hsk_byte_packer u_packer (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_last  (byte_last),
        .word_data  (word_data),
        .word_keep  (word_keep),
        .word_last  (word_last),
        .word_valid (word_valid)
    );

    // header write trails the last byte by one cycle
    // by then len_cnt already includes that byte
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_wr  <= 1'b0;
            len_cnt <= UDP_HDR_BYTES;
        end else begin
            hdr_wr <= byte_valid && byte_last;
            if (hdr_wr) begin
                // reload for the next frame, still counting a byte that lands here
                len_cnt <= byte_valid ? UDP_HDR_BYTES + udp_len_t'(1) : UDP_HDR_BYTES;
            end else if (byte_valid) begin
                len_cnt <= len_cnt + udp_len_t'(1);
            end
        end
    end

    // payload entry {last, keep, data}, dropped when full
    hsk_sync_fifo #(
        .WIDTH (PKT_ENTRY_W),
        .DEPTH (PKT_DEPTH)
    ) u_pkt_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .wr_data  ({word_last, word_keep, word_data}),
        .wr_en    (word_valid),
        .rd_en    (pkt_rd),
        .rd_data  (pkt_dout),
        .rd_valid (data_tvalid)
    );

    // header entry {address, port, length}
    hsk_sync_fifo #(
        .WIDTH (HDR_ENTRY_W),
        .DEPTH (HDR_DEPTH)
    ) u_hdr_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .wr_data  ({ip_i, port_i, len_cnt}),
        .wr_en    (hdr_wr),
        .rd_en    (hdr_rd),
        .rd_data  (hdr_dout),
        .rd_valid (hdr_tvalid)
    );

    // payload stream straight off the fifo head
    assign data_tdata = pkt_dout[$bits(stream_word_t)-1:0];
    assign data_tkeep = pkt_dout[$bits(stream_word_t) +: $bits(keep_t)];
    assign data_tlast = pkt_dout[PKT_ENTRY_W-1];
    assign pkt_rd     = data_tvalid && data_tready;

    // header word with the reserved fields zeroed
    assign hdr_tdata = {16'h0000, hdr_dout[HDR_ENTRY_W-1 -: 32], 4'h0,
                        hdr_dout[$bits(udp_len_t)-1:0]};
    assign hdr_rd    = hdr_tvalid && hdr_tready;

endmodule

`default_nettype wire

//--- sim/hsk_write_cases.txt
# address(hex) port(hex) byte_count(dec) expected_udp_length(dec) stall(0/1)
# a zero byte count is a chip select pulse with no sclk edges
c0a8 1f90 0 8 0
c0a8 1f90 8 16 0
0a01 0035 1 9 0
0a02 0044 3 11 0
ac10 1388 13 21 0
ac11 1389 17 25 0
c0a8 2710 5 13 1
c0a9 2711 16 24 1
0001 ffff 2 10 1
ffff 0001 9 17 1
1234 abcd 24 32 1
8000 0800 1 9 1
0f0f f0f0 7 15 1
a5a5 5a5a 11 19 1
c0a8 1f91 0 8 1
c0a8 1f92 4 12 1
beef cafe 8 16 1
0102 0304 20 28 1
7e57 0bad 3 11 1
c0a8 1f93 6 14 0

//--- sim/tb_hsk_udp_write.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hsk_udp_write;
    import hsk_net_pkg::*;

    localparam int          CLK_HALF_NS = 50;
    // sclk half period counted in aclk cycles
    localparam int          SCLK_HALF   = 4;
    localparam int unsigned SEED        = 32'hb228be66;

    logic         aclk;
    logic         rst_n;
    logic         sclk;
    logic         mosi;
    logic         cs_b;
    ip_lo_t       ip_i;
    udp_port_t    port_i;
    hdr_word_t    hdr_tdata;
    logic         hdr_tvalid;
    logic         hdr_tready;
    stream_word_t data_tdata;
    keep_t        data_tkeep;
    logic         data_tlast;
    logic         data_tvalid;
    logic         data_tready;

    // one entry per line of the cases file
    logic [15:0] case_addr [$];
    logic [15:0] case_port [$];
    int          case_count [$];
    int          case_len [$];
    int          case_stall [$];

    // bytes of the frame being sent
    logic [7:0]  frame_bytes [$];

    // scoreboard queues for expected and seen transfers
    logic [63:0] exp_hdr_q [$];
    logic [63:0] exp_data_q [$];
    logic [7:0]  exp_keep_q [$];
    logic        exp_last_q [$];
    logic [63:0] got_hdr_q [$];
    logic [63:0] got_data_q [$];
    logic [7:0]  got_keep_q [$];
    logic        got_last_q [$];

    logic stall_mode = 1'b0;
    int   watchdog_cycles = 0;

    hsk_udp_write #(
        .PKT_DEPTH (512),
        .HDR_DEPTH (16)
    ) UUT (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .sclk        (sclk),
        .mosi        (mosi),
        .cs_b        (cs_b),
        .ip_i        (ip_i),
        .port_i      (port_i),
        .hdr_tdata   (hdr_tdata),
        .hdr_tvalid  (hdr_tvalid),
        .hdr_tready  (hdr_tready),
        .data_tdata  (data_tdata),
        .data_tkeep  (data_tkeep),
        .data_tlast  (data_tlast),
        .data_tvalid (data_tvalid),
        .data_tready (data_tready)
    );

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF_NS aclk = ~aclk;
    end

    // readies change just after the edge and go random on stall frames
    initial begin
        hdr_tready  = 1'b0;
        data_tready = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            if (stall_mode) begin
                hdr_tready  = 1'($urandom % 2);
                data_tready = 1'($urandom % 2);
            end else begin
                hdr_tready  = 1'b1;
                data_tready = 1'b1;
            end
        end
    end

    // stream monitors
    // nothing moves between the falling edge and the next rising edge
    always @(negedge aclk) begin
        if (rst_n && hdr_tvalid && hdr_tready) begin
            got_hdr_q.push_back(hdr_tdata);
        end
        if (rst_n && data_tvalid && data_tready) begin
            got_data_q.push_back(data_tdata);
            got_keep_q.push_back(data_tkeep);
            got_last_q.push_back(data_tlast);
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge aclk);
        $display("watchdog expired after %0d cycles with transfers outstanding", watchdog_cycles);
        $display("STATUS: FAIL");
        $fatal(1, "simulation timeout");
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    // lines that do not parse (the column notes) are skipped
    task automatic read_cases();
        int          fd;
        int          code;
        string       line;
        logic [15:0] addr_v;
        logic [15:0] port_v;
        int          count_v;
        int          len_v;
        int          stall_v;
        fd = $fopen("sim/hsk_write_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file sim/hsk_write_cases.txt");
            $display("STATUS: FAIL");
            $fatal(1, "missing stimulus");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%h %h %d %d %d\n", addr_v, port_v, count_v, len_v, stall_v);
            if (code == 5) begin
                case_addr.push_back(addr_v);
                case_port.push_back(port_v);
                case_count.push_back(count_v);
                case_len.push_back(len_v);
                case_stall.push_back(stall_v);
            end else begin
                code = $fgets(line, fd);
            end
        end
        $fclose(fd);
    endtask

    // lane n of a word holds byte n and the frame's last word carries tlast
    task automatic build_expected(input int idx);
        logic [63:0] word;
        logic [7:0]  keep;
        int          lane;
        word = '0;
        keep = '0;
        lane = 0;
        for (int i = 0; i < frame_bytes.size(); i++) begin
            word[8*lane +: 8] = frame_bytes[i];
            keep[lane] = 1'b1;
            lane++;
            if (lane == 8 || i == frame_bytes.size() - 1) begin
                exp_data_q.push_back(word);
                exp_keep_q.push_back(keep);
                exp_last_q.push_back(i == frame_bytes.size() - 1);
                word = '0;
                keep = '0;
                lane = 0;
            end
        end
        // an empty frame has no header at all
        if (frame_bytes.size() > 0) begin
            exp_hdr_q.push_back({16'h0000, case_addr[idx], case_port[idx], 4'h0,
                                 udp_len_t'(case_len[idx])});
        end
    endtask

    // SPI mode 0 with mosi set during the low half, MSB first
    task automatic send_frame(input int idx);
        ip_i   = case_addr[idx];
        port_i = case_port[idx];
        cs_b   = 1'b0;
        wait_cycles(SCLK_HALF);
        for (int b = 0; b < case_count[idx]; b++) begin
            for (int k = 7; k >= 0; k--) begin
                mosi = frame_bytes[b][k];
                wait_cycles(SCLK_HALF);
                sclk = 1'b1;
                wait_cycles(SCLK_HALF);
                sclk = 1'b0;
            end
        end
        wait_cycles(SCLK_HALF);
        cs_b = 1'b1;
        // address and port stay put until this frame's header is taken
        while (got_hdr_q.size() < exp_hdr_q.size()) begin
            @(posedge aclk);
        end
        #1;
        wait_cycles(SCLK_HALF);
    endtask

    task automatic wait_drain();
        while (got_hdr_q.size() < exp_hdr_q.size() ||
               got_data_q.size() < exp_data_q.size()) begin
            @(posedge aclk);
        end
        #1;
        wait_cycles(20);
    endtask

    task automatic check_counts(input string when);
        check_value({when, " header count"}, 64'(got_hdr_q.size()), 64'(exp_hdr_q.size()));
        check_value({when, " word count"}, 64'(got_data_q.size()), 64'(exp_data_q.size()));
    endtask

    task automatic compare_transfers();
        check_counts("final");
        foreach (exp_hdr_q[i]) begin
            check_value($sformatf("header %0d", i), got_hdr_q[i], exp_hdr_q[i]);
        end
        foreach (exp_data_q[i]) begin
            check_value($sformatf("word %0d data", i), got_data_q[i], exp_data_q[i]);
            check_value($sformatf("word %0d keep", i), 64'(got_keep_q[i]), 64'(exp_keep_q[i]));
            check_value($sformatf("word %0d last", i), 64'(got_last_q[i]), 64'(exp_last_q[i]));
        end
    endtask

    initial begin
        int total_bytes;
        rst_n  = 1'b0;
        sclk   = 1'b0;
        mosi   = 1'b0;
        cs_b   = 1'b1;
        ip_i   = '0;
        port_i = '0;
        void'($urandom(SEED));
        read_cases();
        total_bytes = 0;
        foreach (case_count[i]) begin
            total_bytes += case_count[i];
        end
        // one byte takes 64 aclk cycles on the wire plus slack per frame
        watchdog_cycles = total_bytes * 64 + case_count.size() * 200 + 1000;

        repeat (4) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        // no output activity without SPI traffic
        for (int c = 0; c < 20; c++) begin
            @(negedge aclk);
            check_value("hdr_tvalid after reset", 64'(hdr_tvalid), 64'd0);
            check_value("data_tvalid after reset", 64'(data_tvalid), 64'd0);
        end
        @(posedge aclk);
        #1;

        for (int f = 0; f < case_count.size(); f++) begin
            stall_mode = case_stall[f] != 0;
            frame_bytes.delete();
            for (int b = 0; b < case_count[f]; b++) begin
                frame_bytes.push_back(8'($urandom));
            end
            check_value($sformatf("cases line %0d length", f), 64'(case_len[f]),
                        64'(case_count[f] + 8));
            build_expected(f);
            send_frame(f);
            if (case_count[f] == 0) begin
                wait_drain();
                wait_cycles(40);
                check_counts("empty frame");
            end
        end

        stall_mode = 1'b0;
        wait_drain();
        compare_transfers();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
